// ==== rtl/ddr3_addr_pkg.sv ====
package ddr3_addr_pkg;

  // address geometry of the scheduler
  // request address is {row, bank, column}, msb down

  // bank address width, fixed at eight banks by the DDR3 standard
  localparam int BANK_BITS = 3;

  // defaults for a 1Gb x16 part
  // top level may override these through its own parameters
  localparam int DEF_ROW_BITS = 13;
  localparam int DEF_COL_BITS = 10;

  // position of address pin A10
  // on READ/WRIT it requests auto-precharge after the access
  // on PREC it selects precharge of all banks
  localparam int AUTO_PRE_BIT = 10;

endpackage

// ==== rtl/ddr3_cmd_pkg.sv ====
package ddr3_cmd_pkg;

  // DDR3 command encoding as {RAS#, CAS#, WE#}
  // all three pins are active low, so NOOP is all ones
  typedef enum logic [2:0] {
    CMD_REFR = 3'b001,
    CMD_PREC = 3'b010,
    CMD_ACTV = 3'b011,
    CMD_WRIT = 3'b100,
    CMD_READ = 3'b101,
    CMD_NOOP = 3'b111
  } ddr3_cmd_e;

  // scheduler states
  // ST_ACTV, ST_READ, ST_WRIT and ST_PREA hold one issued command each
  // ST_REFR waits for the data layer to finish its refresh
  typedef enum logic [2:0] {
    ST_INIT = 3'd0,
    ST_IDLE = 3'd1,
    ST_ACTV = 3'd2,
    ST_READ = 3'd3,
    ST_WRIT = 3'd4,
    ST_PREA = 3'd5,
    ST_REFR = 3'd6
  } sched_state_e;

endpackage

// ==== rtl/ddr3_req_arbiter.sv ====
`timescale 1ns/1ps

module ddr3_req_arbiter #(
  parameter int ROW_BITS = ddr3_addr_pkg::DEF_ROW_BITS,
  parameter int COL_BITS = ddr3_addr_pkg::DEF_COL_BITS
) (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 wr_req_i,
  input  logic                                 wr_last_i,
  input  logic [ROW_BITS+ddr3_addr_pkg::BANK_BITS+COL_BITS-1:0] wr_addr_i,
  input  logic                                 rd_req_i,
  input  logic                                 rd_last_i,
  input  logic [ROW_BITS+ddr3_addr_pkg::BANK_BITS+COL_BITS-1:0] rd_addr_i,
  input  logic                                 accept_i,
  output logic                                 wr_ack_o,
  output logic                                 rd_ack_o,
  output logic                                 sel_valid_o,
  output logic                                 sel_write_o,
  output logic [ddr3_addr_pkg::BANK_BITS-1:0]  sel_bank_o,
  output logic [ROW_BITS-1:0]                  sel_row_o,
  output logic [ROW_BITS-1:0]                  sel_col_o
);

  localparam int ADDR_BITS = ROW_BITS + ddr3_addr_pkg::BANK_BITS + COL_BITS;

  logic [ADDR_BITS-1:0] sel_addr;
  logic                 sel_last;
  logic                 write_q;

  // write port has fixed priority over read
  assign sel_valid_o = wr_req_i | rd_req_i;
  assign sel_write_o = wr_req_i;
  assign sel_addr    = wr_req_i ? wr_addr_i : rd_addr_i;
  assign sel_last    = wr_req_i ? wr_last_i : rd_last_i;

  // split {row, bank, col}
  assign sel_row_o  = sel_addr[ADDR_BITS-1 -: ROW_BITS];
  assign sel_bank_o = sel_addr[COL_BITS +: ddr3_addr_pkg::BANK_BITS];

  always_comb begin
    // column zero extended to the row width of the address bus
    sel_col_o = ROW_BITS'(sel_addr[COL_BITS-1:0]);
    // last of burst closes the row with auto-precharge
    sel_col_o[ddr3_addr_pkg::AUTO_PRE_BIT] = sel_last;
  end

  // accept_i arrives the cycle after the fsm took the request,
  // so remember which port was selected one cycle back
  always_ff @(posedge clock) begin
    if (reset) begin
      write_q  <= 1'b0;
      wr_ack_o <= 1'b0;
      rd_ack_o <= 1'b0;
    end else begin
      write_q  <= sel_write_o;
      // one cycle ack to the accepted port only
      wr_ack_o <= accept_i & write_q;
      rd_ack_o <= accept_i & ~write_q;
    end
  end

endmodule

// ==== rtl/ddr3_bank_tracker.sv ====
`timescale 1ns/1ps

module ddr3_bank_tracker #(
  parameter int ROW_BITS = ddr3_addr_pkg::DEF_ROW_BITS
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                cmd_done_i,
  input  ddr3_cmd_pkg::ddr3_cmd_e             cmd_i,
  input  logic [ddr3_addr_pkg::BANK_BITS-1:0] ba_i,
  input  logic [ROW_BITS-1:0]                 adr_i,
  output logic                                banks_active_o
);

  localparam int NUM_BANKS = 1 << ddr3_addr_pkg::BANK_BITS;

  // one bit per bank, set while a row is open in it
  logic [NUM_BANKS-1:0] open_q;
  logic                 auto_pre;

  assign auto_pre = adr_i[ddr3_addr_pkg::AUTO_PRE_BIT];

  always_ff @(posedge clock) begin
    if (reset) begin
      open_q <= '0;
    end else if (cmd_done_i) begin
      // only commands the data layer has taken change the bank state
      case (cmd_i)
        ddr3_cmd_pkg::CMD_ACTV: begin
          open_q[ba_i] <= 1'b1;
        end
        ddr3_cmd_pkg::CMD_READ, ddr3_cmd_pkg::CMD_WRIT: begin
          // access with auto-precharge closes its bank
          if (auto_pre) begin
            open_q[ba_i] <= 1'b0;
          end
        end
        ddr3_cmd_pkg::CMD_PREC: begin
          // precharge all
          if (auto_pre) begin
            open_q <= '0;
          end
        end
        default: begin
          open_q <= open_q;
        end
      endcase
    end
  end

  assign banks_active_o = |open_q;

endmodule

// ==== rtl/ddr3_cmd_fsm.sv ====
`timescale 1ns/1ps

module ddr3_cmd_fsm #(
  parameter int ROW_BITS = ddr3_addr_pkg::DEF_ROW_BITS
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                cfg_run_i,
  input  logic                                ddl_ref_i,
  input  logic                                ddl_rdy_i,
  input  logic                                sel_valid_i,
  input  logic                                sel_write_i,
  input  logic [ddr3_addr_pkg::BANK_BITS-1:0] sel_bank_i,
  input  logic [ROW_BITS-1:0]                 sel_row_i,
  input  logic [ROW_BITS-1:0]                 sel_col_i,
  input  logic                                banks_active_i,
  output logic                                accept_o,
  output logic                                cmd_done_o,
  output logic                                ddl_req_o,
  output ddr3_cmd_pkg::ddr3_cmd_e             ddl_cmd_o,
  output logic [ddr3_addr_pkg::BANK_BITS-1:0] ddl_ba_o,
  output logic [ROW_BITS-1:0]                 ddl_adr_o
);

  // address for precharge all, only A10 set
  localparam logic [ROW_BITS-1:0] PREA_ADR = ROW_BITS'(1) << ddr3_addr_pkg::AUTO_PRE_BIT;

  ddr3_cmd_pkg::sched_state_e state_q;
  ddr3_cmd_pkg::sched_state_e snext_q;

  // current command, driven to the data layer
  logic                                req_q;
  ddr3_cmd_pkg::ddr3_cmd_e             cmd_q;
  logic [ddr3_addr_pkg::BANK_BITS-1:0] ba_q;
  logic [ROW_BITS-1:0]                 adr_q;

  // pending second command, moves to the current one on completion
  logic                                req_x;
  ddr3_cmd_pkg::ddr3_cmd_e             cmd_x;
  logic [ddr3_addr_pkg::BANK_BITS-1:0] ba_x;
  logic [ROW_BITS-1:0]                 adr_x;

  logic accept_q;
  logic in_idle;
  logic idle_ref;
  logic idle_req;
  logic busy;
  logic shift;

  assign in_idle  = (state_q == ddr3_cmd_pkg::ST_IDLE);
  // refresh wins over a waiting request
  assign idle_ref = in_idle & ddl_ref_i;
  assign idle_req = in_idle & ~ddl_ref_i & sel_valid_i;

  // states that hold an issued command
  assign busy = (state_q == ddr3_cmd_pkg::ST_ACTV) |
                (state_q == ddr3_cmd_pkg::ST_READ) |
                (state_q == ddr3_cmd_pkg::ST_WRIT) |
                (state_q == ddr3_cmd_pkg::ST_PREA) |
                (state_q == ddr3_cmd_pkg::ST_REFR);
  // rdy low freezes all outputs
  assign shift = busy & ddl_rdy_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q  <= ddr3_cmd_pkg::ST_INIT;
      snext_q  <= ddr3_cmd_pkg::ST_IDLE;
      req_q    <= 1'b0;
      cmd_q    <= ddr3_cmd_pkg::CMD_NOOP;
      req_x    <= 1'b0;
      cmd_x    <= ddr3_cmd_pkg::CMD_NOOP;
      accept_q <= 1'b0;
    end else begin
      accept_q <= 1'b0;

      // second command becomes current once the first is taken
      if (shift) begin
        req_q <= req_x;
        cmd_q <= cmd_x;
        req_x <= 1'b0;
        cmd_x <= ddr3_cmd_pkg::CMD_NOOP;
      end

      case (state_q)
        ddr3_cmd_pkg::ST_INIT: begin
          // hold off until configuration lets us run
          if (cfg_run_i) begin
            state_q <= ddr3_cmd_pkg::ST_IDLE;
          end
        end

        ddr3_cmd_pkg::ST_IDLE: begin
          if (idle_ref) begin
            req_q <= 1'b1;
            if (banks_active_i) begin
              // close every open row first, then refresh
              state_q <= ddr3_cmd_pkg::ST_PREA;
              snext_q <= ddr3_cmd_pkg::ST_REFR;
              cmd_q   <= ddr3_cmd_pkg::CMD_PREC;
              req_x   <= 1'b1;
              cmd_x   <= ddr3_cmd_pkg::CMD_REFR;
            end else begin
              state_q <= ddr3_cmd_pkg::ST_REFR;
              snext_q <= ddr3_cmd_pkg::ST_IDLE;
              cmd_q   <= ddr3_cmd_pkg::CMD_REFR;
              req_x   <= 1'b0;
              cmd_x   <= ddr3_cmd_pkg::CMD_NOOP;
            end
          end else if (idle_req) begin
            // RAS# now, CAS# queued behind it
            state_q  <= ddr3_cmd_pkg::ST_ACTV;
            snext_q  <= sel_write_i ? ddr3_cmd_pkg::ST_WRIT : ddr3_cmd_pkg::ST_READ;
            req_q    <= 1'b1;
            cmd_q    <= ddr3_cmd_pkg::CMD_ACTV;
            req_x    <= 1'b1;
            cmd_x    <= sel_write_i ? ddr3_cmd_pkg::CMD_WRIT : ddr3_cmd_pkg::CMD_READ;
            accept_q <= 1'b1;
          end
        end

        ddr3_cmd_pkg::ST_ACTV, ddr3_cmd_pkg::ST_READ,
        ddr3_cmd_pkg::ST_WRIT, ddr3_cmd_pkg::ST_PREA: begin
          if (ddl_rdy_i) begin
            state_q <= snext_q;
            snext_q <= ddr3_cmd_pkg::ST_IDLE;
          end
        end

        ddr3_cmd_pkg::ST_REFR: begin
          // REFR is taken once, then req drops while the refresh runs
          // ddl_ref_i stays high until the refresh is nearly done
          if (ddl_rdy_i && !ddl_ref_i) begin
            state_q <= snext_q;
            snext_q <= ddr3_cmd_pkg::ST_IDLE;
          end
        end

        default: begin
          state_q <= ddr3_cmd_pkg::ST_INIT;
        end
      endcase
    end
  end

  // bank and address registers follow the same load points
  always_ff @(posedge clock) begin
    if (idle_ref) begin
      ba_q  <= '0;
      adr_q <= banks_active_i ? PREA_ADR : '0;
      ba_x  <= '0;
      adr_x <= '0;
    end else if (idle_req) begin
      // row goes with ACTV, column with READ/WRIT
      ba_q  <= sel_bank_i;
      adr_q <= sel_row_i;
      ba_x  <= sel_bank_i;
      adr_x <= sel_col_i;
    end else if (shift) begin
      ba_q  <= ba_x;
      adr_q <= adr_x;
    end
  end

  // a command completes when the data layer is ready for it
  assign cmd_done_o = req_q & ddl_rdy_i;
  assign accept_o   = accept_q;

  assign ddl_req_o = req_q;
  assign ddl_cmd_o = cmd_q;
  assign ddl_ba_o  = ba_q;
  assign ddl_adr_o = adr_q;

endmodule

// ==== rtl/ddr3_sched_top.sv ====
`timescale 1ns/1ps

module ddr3_sched_top #(
  parameter int ROW_BITS = ddr3_addr_pkg::DEF_ROW_BITS,
  parameter int COL_BITS = ddr3_addr_pkg::DEF_COL_BITS
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                cfg_run_i,
  input  logic                                wr_req_i,
  input  logic                                wr_last_i,
  input  logic [ROW_BITS+ddr3_addr_pkg::BANK_BITS+COL_BITS-1:0] wr_addr_i,
  input  logic                                rd_req_i,
  input  logic                                rd_last_i,
  input  logic [ROW_BITS+ddr3_addr_pkg::BANK_BITS+COL_BITS-1:0] rd_addr_i,
  input  logic                                ddl_ref_i,
  input  logic                                ddl_rdy_i,
  output logic                                wr_ack_o,
  output logic                                rd_ack_o,
  output logic                                ddl_req_o,
  output ddr3_cmd_pkg::ddr3_cmd_e             ddl_cmd_o,
  output logic [ddr3_addr_pkg::BANK_BITS-1:0] ddl_ba_o,
  output logic [ROW_BITS-1:0]                 ddl_adr_o
);

  // selected request, arbiter to fsm
  logic                                sel_valid;
  logic                                sel_write;
  logic [ddr3_addr_pkg::BANK_BITS-1:0] sel_bank;
  logic [ROW_BITS-1:0]                 sel_row;
  logic [ROW_BITS-1:0]                 sel_col;

  logic accept;
  logic cmd_done;
  logic banks_active;

  ddr3_req_arbiter #(
    .ROW_BITS (ROW_BITS),
    .COL_BITS (COL_BITS)
  ) u_arbiter (
    .clock       (clock),
    .reset       (reset),
    .wr_req_i    (wr_req_i),
    .wr_last_i   (wr_last_i),
    .wr_addr_i   (wr_addr_i),
    .rd_req_i    (rd_req_i),
    .rd_last_i   (rd_last_i),
    .rd_addr_i   (rd_addr_i),
    .accept_i    (accept),
    .wr_ack_o    (wr_ack_o),
    .rd_ack_o    (rd_ack_o),
    .sel_valid_o (sel_valid),
    .sel_write_o (sel_write),
    .sel_bank_o  (sel_bank),
    .sel_row_o   (sel_row),
    .sel_col_o   (sel_col)
  );

  ddr3_cmd_fsm #(
    .ROW_BITS (ROW_BITS)
  ) u_fsm (
    .clock          (clock),
    .reset          (reset),
    .cfg_run_i      (cfg_run_i),
    .ddl_ref_i      (ddl_ref_i),
    .ddl_rdy_i      (ddl_rdy_i),
    .sel_valid_i    (sel_valid),
    .sel_write_i    (sel_write),
    .sel_bank_i     (sel_bank),
    .sel_row_i      (sel_row),
    .sel_col_i      (sel_col),
    .banks_active_i (banks_active),
    .accept_o       (accept),
    .cmd_done_o     (cmd_done),
    .ddl_req_o      (ddl_req_o),
    .ddl_cmd_o      (ddl_cmd_o),
    .ddl_ba_o       (ddl_ba_o),
    .ddl_adr_o      (ddl_adr_o)
  );

  // tracker watches the command bus as the data layer takes it
  ddr3_bank_tracker #(
    .ROW_BITS (ROW_BITS)
  ) u_tracker (
    .clock          (clock),
    .reset          (reset),
    .cmd_done_i     (cmd_done),
    .cmd_i          (ddl_cmd_o),
    .ba_i           (ddl_ba_o),
    .adr_i          (ddl_adr_o),
    .banks_active_o (banks_active)
  );

endmodule

// ==== tb/ddr3_sched_assertions.sv ====
`timescale 1ns/1ps

module ddr3_sched_assertions #(
  parameter int ROW_BITS = ddr3_addr_pkg::DEF_ROW_BITS
) (
  input logic                                clock,
  input logic                                reset,
  input logic                                wr_ack_o,
  input logic                                rd_ack_o,
  input logic                                ddl_rdy_i,
  input logic                                ddl_req_o,
  input ddr3_cmd_pkg::ddr3_cmd_e             ddl_cmd_o,
  input logic [ddr3_addr_pkg::BANK_BITS-1:0] ddl_ba_o,
  input logic [ROW_BITS-1:0]                 ddl_adr_o
);

  // number of failed assertions
  int fail_count = 0;

  // only one port is acknowledged per accept
  acks_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(wr_ack_o && rd_ack_o))
    else begin
      $error("wr_ack_o and rd_ack_o high together");
      fail_count++;
    end

  // back-pressure freezes the whole command bus
  hold_on_stall: assert property (@(posedge clock) disable iff (reset)
    (ddl_req_o && !ddl_rdy_i) |=> ($stable(ddl_req_o) && $stable(ddl_cmd_o) &&
                                   $stable(ddl_ba_o) && $stable(ddl_adr_o)))
    else begin
      $error("command bus changed while ddl_rdy_i was low");
      fail_count++;
    end

  quiet_after_reset: assert property (@(posedge clock) reset |=> !ddl_req_o)
    else begin
      $error("ddl_req_o high in the cycle after reset");
      fail_count++;
    end

endmodule

bind ddr3_sched_top ddr3_sched_assertions #(
  .ROW_BITS (ROW_BITS)
) u_assertions (
  .clock     (clock),
  .reset     (reset),
  .wr_ack_o  (wr_ack_o),
  .rd_ack_o  (rd_ack_o),
  .ddl_rdy_i (ddl_rdy_i),
  .ddl_req_o (ddl_req_o),
  .ddl_cmd_o (ddl_cmd_o),
  .ddl_ba_o  (ddl_ba_o),
  .ddl_adr_o (ddl_adr_o)
);

// ==== tb/tb_ddr3_sched.sv ====
`timescale 1ns/1ps

module tb_ddr3_sched;

  localparam int ROW_BITS  = ddr3_addr_pkg::DEF_ROW_BITS;
  localparam int COL_BITS  = ddr3_addr_pkg::DEF_COL_BITS;
  localparam int BANK_BITS = ddr3_addr_pkg::BANK_BITS;
  localparam int ADDR_BITS = ROW_BITS + BANK_BITS + COL_BITS;

  logic                    clock;
  logic                    reset;
  logic                    cfg_run_i;
  logic                    wr_req_i;
  logic                    wr_last_i;
  logic [ADDR_BITS-1:0]    wr_addr_i;
  logic                    rd_req_i;
  logic                    rd_last_i;
  logic [ADDR_BITS-1:0]    rd_addr_i;
  logic                    ddl_ref_i;
  logic                    ddl_rdy_i;
  logic                    wr_ack_o;
  logic                    rd_ack_o;
  logic                    ddl_req_o;
  ddr3_cmd_pkg::ddr3_cmd_e ddl_cmd_o;
  logic [BANK_BITS-1:0]    ddl_ba_o;
  logic [ROW_BITS-1:0]     ddl_adr_o;

  integer seed;
  int     errors;
  int     assert_fails;
  int     cmd_count;
  int     wr_count;
  int     rd_count;
  int     ref_count;
  logic   stim_on;

  // requester state, idle gap before the next request
  logic [2:0] wr_gap;
  logic [2:0] rd_gap;
  logic       wr_ack_due;
  logic       rd_ack_due;

  // data layer side: open banks and refresh progress
  logic [(1<<BANK_BITS)-1:0] open_banks;
  logic                      ref_done;
  logic [1:0]                ref_hold;
  logic [3:0]                ref_cool;

  // commands still to be completed, in order
  ddr3_cmd_pkg::ddr3_cmd_e exp_cmd_q[$];
  logic [BANK_BITS-1:0]    exp_ba_q[$];
  logic [ROW_BITS-1:0]     exp_adr_q[$];

  ddr3_sched_top #(
    .ROW_BITS (ROW_BITS),
    .COL_BITS (COL_BITS)
  ) u_dut (
    .clock     (clock),
    .reset     (reset),
    .cfg_run_i (cfg_run_i),
    .wr_req_i  (wr_req_i),
    .wr_last_i (wr_last_i),
    .wr_addr_i (wr_addr_i),
    .rd_req_i  (rd_req_i),
    .rd_last_i (rd_last_i),
    .rd_addr_i (rd_addr_i),
    .ddl_ref_i (ddl_ref_i),
    .ddl_rdy_i (ddl_rdy_i),
    .wr_ack_o  (wr_ack_o),
    .rd_ack_o  (rd_ack_o),
    .ddl_req_o (ddl_req_o),
    .ddl_cmd_o (ddl_cmd_o),
    .ddl_ba_o  (ddl_ba_o),
    .ddl_adr_o (ddl_adr_o)
  );

  always #4 clock = ~clock;

  function automatic logic [31:0] next_random();
    next_random = $random(seed);
  endfunction

  task automatic check_cmd(input string name, input ddr3_cmd_pkg::ddr3_cmd_e exp,
                           input ddr3_cmd_pkg::ddr3_cmd_e act);
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %s, actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic check_bank(input string name, input logic [BANK_BITS-1:0] exp,
                            input logic [BANK_BITS-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input logic [ROW_BITS-1:0] exp,
                            input logic [ROW_BITS-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  task automatic check_ack(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %0b, actual %0b", name, exp, act);
    end
  endtask

  task automatic push_expect(input ddr3_cmd_pkg::ddr3_cmd_e cmd,
                             input logic [BANK_BITS-1:0] ba, input logic [ROW_BITS-1:0] adr);
    exp_cmd_q.push_back(cmd);
    exp_ba_q.push_back(ba);
    exp_adr_q.push_back(adr);
  endtask

  // ACTV with the row, then the access with the column in the low bits
  task automatic expect_access(input logic write, input logic [ADDR_BITS-1:0] addr,
                               input logic last);
    logic [BANK_BITS-1:0] ba;
    logic [ROW_BITS-1:0]  col;
    ba  = addr[COL_BITS +: BANK_BITS];
    col = ROW_BITS'(addr[COL_BITS-1:0]);
    // last of burst asks for auto-precharge on A10
    col[ddr3_addr_pkg::AUTO_PRE_BIT] = last;
    push_expect(ddr3_cmd_pkg::CMD_ACTV, ba, addr[ADDR_BITS-1 -: ROW_BITS]);
    if (write) begin
      push_expect(ddr3_cmd_pkg::CMD_WRIT, ba, col);
      wr_count++;
    end else begin
      push_expect(ddr3_cmd_pkg::CMD_READ, ba, col);
      rd_count++;
    end
  endtask

  task automatic new_request(output logic [ADDR_BITS-1:0] addr, output logic last);
    logic [31:0] r;
    r    = next_random();
    addr = r[ADDR_BITS-1:0];
    last = r[31];
  endtask

  // ack is due one edge after the accepting edge
  task automatic check_acks();
    check_ack("wr ack", wr_ack_due, wr_ack_o);
    check_ack("rd ack", rd_ack_due, rd_ack_o);
    wr_ack_due = 1'b0;
    rd_ack_due = 1'b0;
  endtask

  task automatic serve_data_layer();
    logic [31:0]             r;
    ddr3_cmd_pkg::ddr3_cmd_e cmd;
    logic [BANK_BITS-1:0]    ba;
    logic [ROW_BITS-1:0]     adr;
    if (ddl_req_o && !cfg_run_i) begin
      errors++;
      $display("command requested before cfg_run_i was set");
    end
    // nothing queued, so this opens a sequence
    // inputs still hold what the FSM saw at this edge
    if (ddl_req_o && exp_cmd_q.size() == 0) begin
      if (ddl_ref_i) begin
        if (open_banks != '0) begin
          adr = '0;
          adr[ddr3_addr_pkg::AUTO_PRE_BIT] = 1'b1;
          push_expect(ddr3_cmd_pkg::CMD_PREC, '0, adr);
        end
        push_expect(ddr3_cmd_pkg::CMD_REFR, '0, '0);
        ref_count++;
      end else if (wr_req_i) begin
        // write wins when both ports ask
        expect_access(1'b1, wr_addr_i, wr_last_i);
        wr_ack_due = 1'b1;
      end else if (rd_req_i) begin
        expect_access(1'b0, rd_addr_i, rd_last_i);
        rd_ack_due = 1'b1;
      end else begin
        errors++;
        $display("command requested with no request or refresh pending");
      end
    end
    // stall about one cycle in four
    r = next_random();
    ddl_rdy_i = (r[1:0] != 2'b00);
    if (ddl_req_o && ddl_rdy_i && exp_cmd_q.size() != 0) begin
      // completes on the coming edge
      cmd = exp_cmd_q.pop_front();
      ba  = exp_ba_q.pop_front();
      adr = exp_adr_q.pop_front();
      check_cmd($sformatf("cmd %0d", cmd_count), cmd, ddl_cmd_o);
      check_bank($sformatf("bank %0d", cmd_count), ba, ddl_ba_o);
      check_addr($sformatf("addr %0d", cmd_count), adr, ddl_adr_o);
      cmd_count++;
      case (cmd)
        ddr3_cmd_pkg::CMD_ACTV: begin
          open_banks[ba] = 1'b1;
        end
        ddr3_cmd_pkg::CMD_READ, ddr3_cmd_pkg::CMD_WRIT: begin
          if (adr[ddr3_addr_pkg::AUTO_PRE_BIT]) begin
            open_banks[ba] = 1'b0;
          end
        end
        ddr3_cmd_pkg::CMD_PREC: begin
          open_banks = '0;
        end
        ddr3_cmd_pkg::CMD_REFR: begin
          // refresh runs on for a few cycles with ref still high
          ref_done = 1'b1;
          ref_hold = r[3:2];
        end
        default: begin
        end
      endcase
    end
  endtask

  task automatic drive_requests();
    logic [31:0] r;
    r = next_random();
    // a requester drops its request once it sees the ack
    if (wr_ack_o) begin
      wr_req_i = 1'b0;
      wr_gap   = r[2:0];
    end else if (!wr_req_i && stim_on) begin
      if (wr_gap != 3'd0) begin
        wr_gap = wr_gap - 3'd1;
      end else begin
        wr_req_i = 1'b1;
        new_request(wr_addr_i, wr_last_i);
      end
    end
    if (rd_ack_o) begin
      rd_req_i = 1'b0;
      rd_gap   = r[5:3];
    end else if (!rd_req_i && stim_on) begin
      if (rd_gap != 3'd0) begin
        rd_gap = rd_gap - 3'd1;
      end else begin
        rd_req_i = 1'b1;
        new_request(rd_addr_i, rd_last_i);
      end
    end
  endtask

  task automatic drive_refresh();
    logic [31:0] r;
    r = next_random();
    if (ref_done) begin
      if (ref_hold == 2'd0) begin
        // refresh nearly done, rdy lets the FSM leave REFR
        // req is low here since REFR has already completed
        ddl_ref_i = 1'b0;
        ddl_rdy_i = 1'b1;
        ref_done  = 1'b0;
        ref_cool  = 4'd8;
      end else begin
        ref_hold = ref_hold - 2'd1;
      end
    end else if (!ddl_ref_i) begin
      if (ref_cool != 4'd0) begin
        ref_cool = ref_cool - 4'd1;
      end else if (stim_on && cfg_run_i && r[4:0] == 5'd0) begin
        ddl_ref_i = 1'b1;
      end
    end
  endtask

  // outputs are settled 1 ns after the edge, inputs change there too
  task automatic tick();
    @(posedge clock);
    #1;
    check_acks();
    serve_data_layer();
    drive_requests();
    drive_refresh();
  endtask

  initial begin
    int waited;
    seed       = 32'hd0f;
    clock      = 1'b0;
    reset      = 1'b1;
    cfg_run_i  = 1'b0;
    wr_req_i   = 1'b0;
    wr_last_i  = 1'b0;
    wr_addr_i  = '0;
    rd_req_i   = 1'b0;
    rd_last_i  = 1'b0;
    rd_addr_i  = '0;
    ddl_ref_i  = 1'b0;
    ddl_rdy_i  = 1'b0;
    errors     = 0;
    cmd_count  = 0;
    wr_count   = 0;
    rd_count   = 0;
    ref_count  = 0;
    stim_on    = 1'b0;
    wr_gap     = 3'd0;
    rd_gap     = 3'd0;
    wr_ack_due = 1'b0;
    rd_ack_due = 1'b0;
    open_banks = '0;
    ref_done   = 1'b0;
    ref_hold   = 2'd0;
    ref_cool   = 4'd0;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    // both ports pending, scheduler not yet allowed to run
    stim_on = 1'b1;
    repeat (24) tick();
    cfg_run_i = 1'b1;
    repeat (3000) tick();
    // no new traffic, let everything in flight finish
    stim_on = 1'b0;
    waited  = 0;
    while ((wr_req_i || rd_req_i || ddl_ref_i || ddl_req_o || exp_cmd_q.size() != 0) &&
           waited < 1000) begin
      tick();
      waited++;
    end
    if (waited >= 1000) begin
      errors++;
      $display("timeout: requests or commands still pending after the drain");
    end
    if (wr_count == 0 || rd_count == 0 || ref_count == 0) begin
      errors++;
      $display("stimulus did not reach writes, reads and refreshes");
    end
    assert_fails = u_dut.u_assertions.fail_count;
    errors += assert_fails;
    $display("errors %0d, assertion failures %0d, commands %0d, writes %0d, reads %0d, refreshes %0d",
             errors, assert_fails, cmd_count, wr_count, rd_count, ref_count);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== ddr3_sched_top.f ====
rtl/ddr3_addr_pkg.sv
rtl/ddr3_cmd_pkg.sv
rtl/ddr3_req_arbiter.sv
rtl/ddr3_bank_tracker.sv
rtl/ddr3_cmd_fsm.sv
rtl/ddr3_sched_top.sv
tb/ddr3_sched_assertions.sv
tb/tb_ddr3_sched.sv

// ==== Makefile ====
TOP := tb_ddr3_sched
LOG := sim.log

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	  --top-module $(TOP) -Mdir obj_dir -f ddr3_sched_top.f

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Test FAILED" $(LOG) || ! grep -q "Test OK" $(LOG); then \
	  echo "simulation reported failure"; exit 1; fi

lint:
	verilator --lint-only --timing --timescale 1ns/1ps \
	  --top-module $(TOP) -f ddr3_sched_top.f

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean
